// ==== src/ncpu_isa_pkg.sv ====
// Instruction set encodings
package ncpu_isa_pkg;

   // Instruction word width
   localparam int INSN_W = 32;

   // Opcode field position
   localparam int OPC_HI = 31;
   localparam int OPC_LO = 26;
   localparam int OPC_W  = OPC_HI - OPC_LO + 1;

   // Unconditional relative jump
   localparam logic [OPC_W-1:0] OP_JMP  = 6'h01;
   // Relative jump with link, pushes the return address
   localparam logic [OPC_W-1:0] OP_JMPL = 6'h02;
   // Conditional branch, taken on flag set
   localparam logic [OPC_W-1:0] OP_BT   = 6'h03;
   // Conditional branch, taken on flag clear
   localparam logic [OPC_W-1:0] OP_BF   = 6'h04;
   // Far jump to the return-stack target
   localparam logic [OPC_W-1:0] OP_RET  = 6'h05;

   // Jump offset, signed word offset in bits 25..0
   localparam int JOFF_W = 26;
   // Branch offset, signed word offset in bits 15..0
   localparam int BOFF_W = 16;

endpackage

// ==== src/ncpu_fetch_pkg.sv ====
// Fetch subsystem sizes
package ncpu_fetch_pkg;

   // Byte address and word PC widths
   localparam int AW  = 8;
   localparam int PCW = AW - 2;

   // Word PC after reset
   localparam logic [PCW-1:0] RESET_VEC = '0;

   // Idle cycles between reset release and first fetch
   localparam int RST_DLY   = 2;
   localparam int RST_CNT_W = $clog2(RST_DLY + 1);

   // Counter table, starts weakly not taken
   localparam int         BHT_BITS = 4;
   localparam int         BHT_SIZE = 1 << BHT_BITS;
   localparam logic [1:0] BHT_INIT = 2'd1;

   // Return-address stack
   localparam int RAS_DEPTH = 4;
   localparam int RAS_PW    = $clog2(RAS_DEPTH);

   localparam int IMEM_WORDS = 64;

endpackage

// ==== src/imem.sv ====
// Instruction memory
`timescale 1ns/1ps

module imem
   import ncpu_isa_pkg::*, ncpu_fetch_pkg::*;
(
   input  logic              clk,
   input  logic              reset,
   input  logic              ld_we,
   input  logic [PCW-1:0]    ld_addr,
   input  logic [INSN_W-1:0] ld_data,
   input  logic [PCW-1:0]    ibus_addr,
   input  logic              ibus_ready,
   output logic              ibus_valid,
   output logic [INSN_W-1:0] ibus_insn,
   output logic [PCW-1:0]    ibus_id
);

   logic [INSN_W-1:0] mem [IMEM_WORDS];
   logic              load;

   // Fetch a new word when empty or when the current one is taken
   assign load = ~ibus_valid | ibus_ready;

   // Program load port
   always_ff @(posedge clk) begin
      if (ld_we) begin
         mem[ld_addr] <= ld_data;
      end
   end

   // Response valid, set once the first read has landed
   always_ff @(posedge clk) begin
      if (reset) begin
         ibus_valid <= 1'b0;
      end else if (load) begin
         ibus_valid <= 1'b1;
      end
   end

   // Response word and the PC it was read from
   // Held while the fetch unit stalls
   always_ff @(posedge clk) begin
      if (load) begin
         ibus_insn <= mem[ibus_addr];
         ibus_id   <= ibus_addr;
      end
   end

   // Loading only allowed while fetch is idle
   a_no_load_during_fetch : assert property (
      @(posedge clk) disable iff (reset)
      !(ld_we && ibus_valid && ibus_ready)
   ) else $error("imem: load port written during an instruction handshake");

endmodule

// ==== src/ipdu.sv ====
// Instruction predecoder
`timescale 1ns/1ps

module ipdu
   import ncpu_isa_pkg::*, ncpu_fetch_pkg::*;
(
   input  logic [INSN_W-1:0] insn,
   output logic              is_jmp,
   output logic              is_link,
   output logic              is_bcc,
   output logic              is_bt,
   output logic              is_ret,
   output logic [PCW-1:0]    rel_offset
);

   logic [OPC_W-1:0] opc;

   assign opc = insn[OPC_HI:OPC_LO];

   // Instruction classes
   assign is_jmp  = (opc == OP_JMP);
   assign is_link = (opc == OP_JMPL);
   assign is_bt   = (opc == OP_BT);
   // Both branch flavors share one class
   assign is_bcc  = is_bt | (opc == OP_BF);
   assign is_ret  = (opc == OP_RET);

   // Jump and branch offsets both start at bit 0 and are wider than PCW
   // PC math wraps at PCW bits
   // Either sign-extended field reduces to its low PCW bits
   assign rel_offset = insn[PCW-1:0];

endmodule

// ==== src/bpu.sv ====
// Branch predictor
`timescale 1ns/1ps

module bpu
   import ncpu_fetch_pkg::*;
(
   input  logic           clk,
   input  logic           reset,
   input  logic           rd,
   input  logic [PCW-1:0] pc,
   input  logic           is_bcc,
   input  logic           push,
   input  logic [PCW-1:0] push_pc,
   input  logic           res_valid,
   input  logic [PCW-1:0] res_pc,
   input  logic           res_taken,
   output logic           taken,
   output logic [PCW-1:0] ret_tgt
);

   logic [1:0]        bht [BHT_SIZE];
   logic [PCW-1:0]    ras [RAS_DEPTH];
   logic [RAS_PW-1:0] ras_top;
   logic [RAS_PW-1:0] ras_nxt;
   logic [RAS_PW:0]   ras_cnt;
   logic              ras_empty;
   logic              ras_full;
   logic              pop;
   logic [1:0]        res_ctr;

   // Counter msb gives the prediction, only for branches
   assign taken = is_bcc & bht[pc[BHT_BITS-1:0]][1];

   // A read from a non-branch is a return pop
   assign pop = rd & ~is_bcc;

   assign ras_nxt   = ras_top + RAS_PW'(1);
   assign ras_empty = (ras_cnt == '0);
   assign ras_full  = (ras_cnt == (RAS_PW + 1)'(RAS_DEPTH));
   // Empty stack falls back to the reset vector
   assign ret_tgt   = ras_empty ? RESET_VEC : ras[ras_top];

   assign res_ctr = bht[res_pc[BHT_BITS-1:0]];

   // Saturating update from the resolve port
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < BHT_SIZE; i++) begin
            bht[i] <= BHT_INIT;
         end
      end else if (res_valid) begin
         if (res_taken && res_ctr != 2'd3) begin
            bht[res_pc[BHT_BITS-1:0]] <= res_ctr + 2'd1;
         end else if (!res_taken && res_ctr != 2'd0) begin
            bht[res_pc[BHT_BITS-1:0]] <= res_ctr - 2'd1;
         end
      end
   end

   // Stack pointer and depth
   // Circular, a full push overwrites the oldest entry
   always_ff @(posedge clk) begin
      if (reset) begin
         ras_top <= '0;
         ras_cnt <= '0;
      end else if (push) begin
         ras_top <= ras_nxt;
         if (!ras_full) begin
            ras_cnt <= ras_cnt + (RAS_PW + 1)'(1);
         end
      end else if (pop && !ras_empty) begin
         ras_top <= ras_top - RAS_PW'(1);
         ras_cnt <= ras_cnt - (RAS_PW + 1)'(1);
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         ras[ras_nxt] <= push_pc;
      end
   end

   // One fetched word cannot both link and return
   a_push_pop_excl : assert property (
      @(posedge clk) disable iff (reset)
      !(push && pop)
   ) else $error("bpu: return stack push and pop in the same cycle");

endmodule

// ==== src/ifu.sv ====
// Instruction fetch unit
`timescale 1ns/1ps

module ifu
   import ncpu_isa_pkg::*, ncpu_fetch_pkg::*;
(
   input  logic              clk,
   input  logic              reset,
   input  logic              ibus_valid,
   input  logic [INSN_W-1:0] ibus_insn,
   input  logic [PCW-1:0]    ibus_id,
   output logic              ibus_ready,
   output logic [PCW-1:0]    ibus_addr,
   input  logic              flush,
   input  logic [PCW-1:0]    flush_tgt,
   output logic              bpu_rd,
   output logic [PCW-1:0]    bpu_pc,
   output logic              bpu_is_bcc,
   output logic              bpu_push,
   output logic [PCW-1:0]    bpu_push_pc,
   input  logic              bpu_taken,
   input  logic [PCW-1:0]    bpu_ret_tgt,
   input  logic              dec_ready,
   output logic              dec_valid,
   output logic [INSN_W-1:0] dec_insn,
   output logic [PCW-1:0]    dec_pc,
   output logic              dec_op_jmprel,
   output logic              dec_jmprel_link,
   output logic              dec_op_jmpfar,
   output logic              dec_specul_jmprel,
   output logic              dec_specul_jmpfar,
   output logic [PCW-1:0]    dec_specul_tgt,
   output logic              dec_specul_bcc
);

   logic [RST_CNT_W-1:0] dly_cnt;
   logic                 started;
   logic                 fetch_ready;
   logic                 accept;
   logic                 live;
   logic                 is_jmp;
   logic                 is_link;
   logic                 is_bcc;
   logic                 is_bt;
   logic                 is_ret;
   logic [PCW-1:0]       rel_offset;
   logic [PCW-1:0]       pc_plus1;
   logic [PCW-1:0]       rel_tgt;
   logic                 jmprel_taken;
   logic [PCW-1:0]       specul_tgt_nxt;
   logic                 specul_bcc_nxt;

   ipdu ipdu_i (
      .insn       (ibus_insn),
      .is_jmp     (is_jmp),
      .is_link    (is_link),
      .is_bcc     (is_bcc),
      .is_bt      (is_bt),
      .is_ret     (is_ret),
      .rel_offset (rel_offset)
   );

   // Hold off fetch for a few cycles after reset
   always_ff @(posedge clk) begin
      if (reset) begin
         dly_cnt <= '0;
      end else if (!started) begin
         dly_cnt <= dly_cnt + RST_CNT_W'(1);
      end
   end

   assign started = (dly_cnt == RST_CNT_W'(RST_DLY));

   // Buffer free or draining this cycle
   assign fetch_ready = ~dec_valid | dec_ready;
   assign ibus_ready  = started & fetch_ready;
   assign accept      = ibus_valid & ibus_ready;
   // Flush kills the word being accepted
   assign live        = ~flush;

   // Candidate targets
   assign pc_plus1     = ibus_id + PCW'(1);
   assign rel_tgt      = ibus_id + rel_offset;
   assign jmprel_taken = is_jmp | is_link | bpu_taken;

   // Next fetch address by priority
   always_comb begin
      if (flush) begin
         ibus_addr = flush_tgt;
      end else if (!ibus_valid) begin
         ibus_addr = RESET_VEC;
      end else if (is_ret) begin
         ibus_addr = bpu_ret_tgt;
      end else if (jmprel_taken) begin
         ibus_addr = rel_tgt;
      end else begin
         ibus_addr = pc_plus1;
      end
   end

   // Predictor requests, state moves only for accepted live words
   assign bpu_pc      = ibus_id;
   assign bpu_is_bcc  = is_bcc;
   assign bpu_rd      = accept & live & (is_bcc | is_ret);
   assign bpu_push    = accept & live & is_link;
   assign bpu_push_pc = pc_plus1;

   // Branch keeps the path not predicted, return keeps the popped target
   assign specul_tgt_nxt = is_bcc ? (bpu_taken ? pc_plus1 : rel_tgt) : bpu_ret_tgt;
   // Predicted flag value, inverted sense for BF
   assign specul_bcc_nxt = is_bcc & (is_bt ? bpu_taken : ~bpu_taken);

   // Decode handoff valid
   always_ff @(posedge clk) begin
      if (reset) begin
         dec_valid <= 1'b0;
      end else if (fetch_ready) begin
         dec_valid <= accept;
      end
   end

   // Decode handoff payload
   // PC and speculation data pass through a flush unmasked
   always_ff @(posedge clk) begin
      if (accept) begin
         dec_pc            <= ibus_id;
         dec_specul_tgt    <= specul_tgt_nxt;
         dec_specul_bcc    <= specul_bcc_nxt;
         dec_insn          <= ibus_insn & {INSN_W{live}};
         dec_op_jmprel     <= (is_jmp | is_link | is_bcc) & live;
         dec_jmprel_link   <= is_link & live;
         dec_op_jmpfar     <= is_ret & live;
         dec_specul_jmprel <= is_bcc & live;
         dec_specul_jmpfar <= is_ret & live;
      end
   end

   // Return and a taken relative jump cannot both steer fetch
   a_far_rel_excl : assert property (
      @(posedge clk) disable iff (reset)
      !(ibus_valid && is_ret && jmprel_taken)
   ) else $error("ifu: far jump and taken relative jump at once");

   // Flush only when a word can be taken
   a_flush_when_ready : assert property (
      @(posedge clk) disable iff (reset)
      flush |-> ibus_ready
   ) else $error("ifu: flush while fetch is not ready");

endmodule

// ==== src/fetch_top.sv ====
// Instruction fetch top level
`timescale 1ns/1ps

module fetch_top
   import ncpu_isa_pkg::*, ncpu_fetch_pkg::*;
(
   input  logic              clk,
   input  logic              reset,
   input  logic              ld_we,
   input  logic [PCW-1:0]    ld_addr,
   input  logic [INSN_W-1:0] ld_data,
   input  logic              flush,
   input  logic [PCW-1:0]    flush_tgt,
   input  logic              res_valid,
   input  logic [PCW-1:0]    res_pc,
   input  logic              res_taken,
   input  logic              dec_ready,
   output logic              dec_valid,
   output logic [INSN_W-1:0] dec_insn,
   output logic [PCW-1:0]    dec_pc,
   output logic              dec_op_jmprel,
   output logic              dec_jmprel_link,
   output logic              dec_op_jmpfar,
   output logic              dec_specul_jmprel,
   output logic              dec_specul_jmpfar,
   output logic [PCW-1:0]    dec_specul_tgt,
   output logic              dec_specul_bcc
);

   // Instruction bus
   logic              ibus_valid;
   logic              ibus_ready;
   logic [INSN_W-1:0] ibus_insn;
   logic [PCW-1:0]    ibus_id;
   logic [PCW-1:0]    ibus_addr;

   // Predictor requests and answers
   logic              bpu_rd;
   logic [PCW-1:0]    bpu_pc;
   logic              bpu_is_bcc;
   logic              bpu_push;
   logic [PCW-1:0]    bpu_push_pc;
   logic              bpu_taken;
   logic [PCW-1:0]    bpu_ret_tgt;

   imem imem_i (
      .clk        (clk),
      .reset      (reset),
      .ld_we      (ld_we),
      .ld_addr    (ld_addr),
      .ld_data    (ld_data),
      .ibus_addr  (ibus_addr),
      .ibus_ready (ibus_ready),
      .ibus_valid (ibus_valid),
      .ibus_insn  (ibus_insn),
      .ibus_id    (ibus_id)
   );

   ifu ifu_i (
      .clk               (clk),
      .reset             (reset),
      .ibus_valid        (ibus_valid),
      .ibus_insn         (ibus_insn),
      .ibus_id           (ibus_id),
      .ibus_ready        (ibus_ready),
      .ibus_addr         (ibus_addr),
      .flush             (flush),
      .flush_tgt         (flush_tgt),
      .bpu_rd            (bpu_rd),
      .bpu_pc            (bpu_pc),
      .bpu_is_bcc        (bpu_is_bcc),
      .bpu_push          (bpu_push),
      .bpu_push_pc       (bpu_push_pc),
      .bpu_taken         (bpu_taken),
      .bpu_ret_tgt       (bpu_ret_tgt),
      .dec_ready         (dec_ready),
      .dec_valid         (dec_valid),
      .dec_insn          (dec_insn),
      .dec_pc            (dec_pc),
      .dec_op_jmprel     (dec_op_jmprel),
      .dec_jmprel_link   (dec_jmprel_link),
      .dec_op_jmpfar     (dec_op_jmpfar),
      .dec_specul_jmprel (dec_specul_jmprel),
      .dec_specul_jmpfar (dec_specul_jmpfar),
      .dec_specul_tgt    (dec_specul_tgt),
      .dec_specul_bcc    (dec_specul_bcc)
   );

   bpu bpu_i (
      .clk       (clk),
      .reset     (reset),
      .rd        (bpu_rd),
      .pc        (bpu_pc),
      .is_bcc    (bpu_is_bcc),
      .push      (bpu_push),
      .push_pc   (bpu_push_pc),
      .res_valid (res_valid),
      .res_pc    (res_pc),
      .res_taken (res_taken),
      .taken     (bpu_taken),
      .ret_tgt   (bpu_ret_tgt)
   );

endmodule

// ==== sim/fetch_tb.sv ====
// Fetch subsystem testbench
`timescale 1ns/1ps

module fetch_tb
   import ncpu_isa_pkg::*, ncpu_fetch_pkg::*;
();

   localparam int NT       = 8;
   localparam int WAIT_MAX = 200;
   // Filler opcode that decodes as a plain instruction
   localparam logic [OPC_W-1:0] PLAIN_OPC = 6'h10;

   logic              clk;
   logic              reset;
   logic              ld_we;
   logic [PCW-1:0]    ld_addr;
   logic [INSN_W-1:0] ld_data;
   logic              flush;
   logic [PCW-1:0]    flush_tgt;
   logic              res_valid;
   logic [PCW-1:0]    res_pc;
   logic              res_taken;
   logic              dec_ready;
   logic              dec_valid;
   logic [INSN_W-1:0] dec_insn;
   logic [PCW-1:0]    dec_pc;
   logic              dec_op_jmprel;
   logic              dec_jmprel_link;
   logic              dec_op_jmpfar;
   logic              dec_specul_jmprel;
   logic              dec_specul_jmpfar;
   logic [PCW-1:0]    dec_specul_tgt;
   logic              dec_specul_bcc;

   // Test table, one row per test
   // Resolve base trains base and base+1 taken twice
   // Negative resolve base means no training
   string t_name   [NT] = '{"plain_run", "jump_link_ret", "branch_cold", "branch_warm",
                            "flush_mid", "stall_plain", "stall_jumps", "stall_branch"};
   int    t_start  [NT] = '{8, 16, 40, 40, 8, 8, 16, 40};
   int    t_fl_cyc [NT] = '{-1, -1, -1, -1, 2, -1, -1, -1};
   int    t_fl_tgt [NT] = '{0, 0, 0, 0, 16, 0, 0, 0};
   int    t_res    [NT] = '{-1, -1, -1, 40, -1, -1, -1, -1};
   int    t_items  [NT] = '{5, 6, 3, 5, 6, 5, 6, 5};
   bit    t_stall  [NT] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1};

   // Reference model state
   logic [INSN_W-1:0] prog [IMEM_WORDS];
   logic [1:0]        bht_m [BHT_SIZE];
   logic [PCW-1:0]    ras_q [$];
   logic [PCW-1:0]    mpc = RESET_VEC;
   int                fl_idx_q [$];
   logic [PCW-1:0]    fl_tgt_q [$];

   int    n_out          = 0;
   int    last_flush_idx = 0;
   int    errors         = 0;
   bit    stall_mode     = 1'b0;
   bit    timed_out      = 1'b0;
   string cur_test       = "startup";

   fetch_top fetch_top_i (
      .clk               (clk),
      .reset             (reset),
      .ld_we             (ld_we),
      .ld_addr           (ld_addr),
      .ld_data           (ld_data),
      .flush             (flush),
      .flush_tgt         (flush_tgt),
      .res_valid         (res_valid),
      .res_pc            (res_pc),
      .res_taken         (res_taken),
      .dec_ready         (dec_ready),
      .dec_valid         (dec_valid),
      .dec_insn          (dec_insn),
      .dec_pc            (dec_pc),
      .dec_op_jmprel     (dec_op_jmprel),
      .dec_jmprel_link   (dec_jmprel_link),
      .dec_op_jmpfar     (dec_op_jmpfar),
      .dec_specul_jmprel (dec_specul_jmprel),
      .dec_specul_jmpfar (dec_specul_jmpfar),
      .dec_specul_tgt    (dec_specul_tgt),
      .dec_specul_bcc    (dec_specul_bcc)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function automatic logic [INSN_W-1:0] enc_jump(logic [OPC_W-1:0] op, int off);
      logic [JOFF_W-1:0] f;
      f = JOFF_W'(off);
      return {op, f};
   endfunction

   function automatic logic [INSN_W-1:0] enc_branch(logic [OPC_W-1:0] op, int off);
      logic [BOFF_W-1:0] f;
      f = BOFF_W'(off);
      return {op, {(INSN_W - OPC_W - BOFF_W){1'b0}}, f};
   endfunction

   // Test programs where every path ends in a jump to itself
   function automatic void build_prog();
      for (int a = 0; a < IMEM_WORDS; a++) begin
         prog[a] = {PLAIN_OPC, {(INSN_W - OPC_W - PCW){1'b0}}, PCW'(a)};
      end
      prog[0]  = enc_jump(OP_JMP, 0);
      prog[12] = enc_jump(OP_JMP, 0);
      // Jump, call, return
      prog[17] = enc_jump(OP_JMP, 3);
      prog[20] = enc_jump(OP_JMPL, 10);
      prog[31] = {OP_RET, {(INSN_W - OPC_W){1'b0}}};
      prog[21] = enc_jump(OP_JMP, 0);
      // Branch pair with both directions reachable
      prog[40] = enc_branch(OP_BT, 4);
      prog[41] = enc_branch(OP_BF, 5);
      prog[42] = enc_jump(OP_JMP, 0);
      prog[45] = enc_jump(OP_JMP, -4);
      prog[46] = enc_jump(OP_JMP, 0);
   endfunction

   task automatic check_val(string field, logic [INSN_W-1:0] exp_v, logic [INSN_W-1:0] act_v);
      if (act_v !== exp_v) begin
         $display("CHECK FAILED %s item %0d %s: expected %h, actual %h",
                  cur_test, n_out, field, exp_v, act_v);
         errors++;
      end
   endtask

   // Next expected item from the ISA, predictor and priority rules
   task automatic check_item();
      logic [INSN_W-1:0] w;
      logic [OPC_W-1:0]  opc;
      logic [PCW-1:0]    pc;
      logic [PCW-1:0]    off;
      logic [PCW-1:0]    rtop;
      logic [PCW-1:0]    alt;
      logic [PCW-1:0]    link;
      logic [PCW-1:0]    nxt;
      logic [PCW-1:0]    ftgt;
      bit                fl;
      bit                is_j;
      bit                is_l;
      bit                is_bt;
      bit                is_bf;
      bit                is_b;
      bit                is_r;
      bit                pred;
      pc   = mpc;
      w    = prog[pc];
      opc  = w[OPC_HI:OPC_LO];
      fl   = 1'b0;
      ftgt = RESET_VEC;
      if (fl_idx_q.size() > 0 && fl_idx_q[0] == n_out) begin
         fl   = 1'b1;
         ftgt = fl_tgt_q.pop_front();
         void'(fl_idx_q.pop_front());
      end
      is_j  = (opc == OP_JMP);
      is_l  = (opc == OP_JMPL);
      is_bt = (opc == OP_BT);
      is_bf = (opc == OP_BF);
      is_r  = (opc == OP_RET);
      is_b  = is_bt || is_bf;
      if (is_b) begin
         off = PCW'($signed(w[BOFF_W-1:0]));
      end else begin
         off = PCW'($signed(w[JOFF_W-1:0]));
      end
      pred = is_b && (bht_m[pc[BHT_BITS-1:0]] >= 2'd2);
      rtop = (ras_q.size() > 0) ? ras_q[$] : RESET_VEC;
      link = pc + PCW'(1);
      // Path not predicted
      alt  = pred ? link : pc + off;
      if (fl) begin
         nxt = ftgt;
      end else if (is_r) begin
         nxt = rtop;
      end else if (is_j || is_l || pred) begin
         nxt = pc + off;
      end else begin
         nxt = link;
      end
      check_val("pc", INSN_W'(pc), INSN_W'(dec_pc));
      check_val("insn", fl ? '0 : w, dec_insn);
      check_val("op_jmprel", INSN_W'(!fl && (is_j || is_l || is_b)), INSN_W'(dec_op_jmprel));
      check_val("jmprel_link", INSN_W'(!fl && is_l), INSN_W'(dec_jmprel_link));
      check_val("op_jmpfar", INSN_W'(!fl && is_r), INSN_W'(dec_op_jmpfar));
      check_val("specul_jmprel", INSN_W'(!fl && is_b), INSN_W'(dec_specul_jmprel));
      check_val("specul_jmpfar", INSN_W'(!fl && is_r), INSN_W'(dec_specul_jmpfar));
      if (is_b) begin
         check_val("specul_tgt", INSN_W'(alt), INSN_W'(dec_specul_tgt));
         check_val("specul_bcc", INSN_W'(is_bt ? pred : !pred), INSN_W'(dec_specul_bcc));
      end
      if (is_r) begin
         check_val("specul_tgt", INSN_W'(rtop), INSN_W'(dec_specul_tgt));
      end
      // Return stack moves only for live words
      if (!fl && is_l) begin
         ras_q.push_back(link);
         if (ras_q.size() > RAS_DEPTH) begin
            void'(ras_q.pop_front());
         end
      end
      if (!fl && is_r && ras_q.size() > 0) begin
         void'(ras_q.pop_back());
      end
      mpc = nxt;
   endtask

   // Decode port monitor sampling values from before the edge
   always @(posedge clk) begin
      if (!reset) begin
         // Flushed word is the one after the buffered item
         if (flush) begin
            last_flush_idx = n_out + int'(dec_valid);
            fl_idx_q.push_back(last_flush_idx);
            fl_tgt_q.push_back(flush_tgt);
         end
         if (dec_valid && dec_ready) begin
            check_item();
            n_out++;
         end
      end
   end

   task automatic tick();
      @(posedge clk);
      flush     <= 1'b0;
      res_valid <= 1'b0;
      if (stall_mode) begin
         dec_ready <= ($urandom_range(3) != 0);
      end else begin
         dec_ready <= 1'b1;
      end
   endtask

   task automatic send_flush(logic [PCW-1:0] tgt);
      tick();
      flush     <= 1'b1;
      flush_tgt <= tgt;
      dec_ready <= 1'b1;
      tick();
   endtask

   task automatic train_taken(logic [PCW-1:0] pc);
      tick();
      res_valid <= 1'b1;
      res_pc    <= pc;
      res_taken <= 1'b1;
      if (bht_m[pc[BHT_BITS-1:0]] != 2'd3) begin
         bht_m[pc[BHT_BITS-1:0]] = bht_m[pc[BHT_BITS-1:0]] + 2'd1;
      end
   endtask

   task automatic wait_items(int count);
      int target;
      int cnt;
      tick();
      target = last_flush_idx + 1 + count;
      cnt    = 0;
      while (n_out < target && cnt < WAIT_MAX) begin
         tick();
         cnt++;
      end
      if (n_out < target) begin
         $display("Timeout in %s: only %0d of %0d decode items arrived", cur_test, n_out, target);
         errors++;
         timed_out = 1'b1;
      end
   endtask

   task automatic wait_first_item();
      int cnt;
      cnt = 0;
      while (!dec_valid && cnt < WAIT_MAX) begin
         @(posedge clk);
         cnt++;
      end
      if (!dec_valid) begin
         $display("Timeout: no decode item appeared after reset");
         errors++;
         timed_out = 1'b1;
      end
   endtask

   // Rest of the program goes in while the decode port stalls
   task automatic load_rest();
      for (int a = 1; a < IMEM_WORDS; a++) begin
         ld_we   <= 1'b1;
         ld_addr <= PCW'(a);
         ld_data <= prog[a];
         @(posedge clk);
      end
      ld_we <= 1'b0;
   endtask

   initial begin
      build_prog();
      for (int i = 0; i < BHT_SIZE; i++) begin
         bht_m[i] = 2'd1;
      end
      void'($urandom(32'h31c0));
      reset     = 1'b1;
      ld_we     = 1'b1;
      ld_addr   = RESET_VEC;
      ld_data   = prog[0];
      flush     = 1'b0;
      flush_tgt = '0;
      res_valid = 1'b0;
      res_pc    = '0;
      res_taken = 1'b0;
      dec_ready = 1'b0;
      // Reset word goes in during reset
      repeat (3) @(posedge clk);
      reset <= 1'b0;
      ld_we <= 1'b0;
      wait_first_item();
      if (!timed_out) begin
         load_rest();
      end
      for (int t = 0; t < NT && !timed_out; t++) begin
         cur_test   = t_name[t];
         stall_mode = t_stall[t];
         if (t_res[t] >= 0) begin
            for (int k = 0; k < 2; k++) begin
               train_taken(PCW'(t_res[t]));
               train_taken(PCW'(t_res[t] + 1));
            end
         end
         send_flush(PCW'(t_start[t]));
         if (t_fl_cyc[t] >= 0) begin
            repeat (t_fl_cyc[t]) tick();
            send_flush(PCW'(t_fl_tgt[t]));
         end
         wait_items(t_items[t]);
      end
      $display("Checked %0d decode items, %0d errors", n_out, errors);
      if (errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// ==== all.f ====
src/ncpu_isa_pkg.sv
src/ncpu_fetch_pkg.sv
src/imem.sv
src/ipdu.sv
src/bpu.sv
src/ifu.sv
src/fetch_top.sv
sim/fetch_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the fetch testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module fetch_tb -f all.f -o fetch_sim \
   && ./obj_dir/fetch_sim > sim.log 2>&1 \
   || echo "Build or run aborted"
cat sim.log 2>/dev/null
grep -qx "Simulation passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
